// ==== files.f ====
+incdir+testbench
rtl/wiscPkg.sv
rtl/ctrlIf.sv
rtl/fetchUnit.sv
rtl/control.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/memWriteback.sv
rtl/wiscCore.sv
testbench/tbWisc.sv

// ==== testbench/wiscModel.svh ====
// instruction-level reference model with registers, data memory, pc,
// predicted strobes per instruction and the commit step
`ifndef WISC_MODEL_SVH
`define WISC_MODEL_SVH

wiscPkg::word_t   mReg [8];
wiscPkg::word_t   mMem [256];
wiscPkg::word_t   mPc;
logic             mHalted;
logic             expWbEn;
wiscPkg::regIdx_t expWbReg;
wiscPkg::word_t   expWbData;
logic             expMemWrEn;
wiscPkg::word_t   expMemAddr;
wiscPkg::word_t   expMemWrData;
wiscPkg::word_t   expNextPc;
logic             expHalt;

function automatic wiscPkg::word_t rotLeft(input wiscPkg::word_t x, input int n);
        logic [31:0] t;
        t = {16'b0, x} << n;
        return t[15:0] | t[31:16];      // bits shifted out wrap around
endfunction

task automatic modelReset();
        for (int i = 0; i < 8; i++) mReg[i] = '0;
        for (int i = 0; i < 256; i++) mMem[i] = '0;
        mPc     = '0;
        mHalted = 1'b0;
endtask

task automatic setWb(input wiscPkg::regIdx_t idx, input wiscPkg::word_t data);
        expWbEn   = 1'b1;
        expWbReg  = idx;
        expWbData = data;
endtask

task automatic setStore(input wiscPkg::word_t addr, input wiscPkg::word_t data);
        expMemWrEn   = 1'b1;
        expMemAddr   = addr;
        expMemWrData = data;
endtask

// expected strobes of one instruction with the state left untouched
task automatic predictStep(input wiscPkg::word_t ins);
        wiscPkg::opcode_t op;
        wiscPkg::word_t   rs, rt, i5s, i5z, i8s, i11, pc2, addr, rev;
        logic [16:0]      s;
        logic             cond;
        op   = ins[15:11];
        rs   = mReg[ins[10:8]];
        rt   = mReg[ins[7:5]];
        i5s  = {{11{ins[4]}}, ins[4:0]};
        i5z  = {11'b0, ins[4:0]};
        i8s  = {{8{ins[7]}}, ins[7:0]};
        i11  = {{5{ins[10]}}, ins[10:0]};
        pc2  = mPc + 16'd2;
        addr = rs + i5s;                // ld/st/stu effective address
        s    = {1'b0, rs} + {1'b0, rt};
        for (int i = 0; i < 16; i++) rev[i] = rs[15 - i];
        expWbEn      = 1'b0;
        expWbReg     = '0;
        expWbData    = '0;
        expMemWrEn   = 1'b0;
        expMemAddr   = '0;
        expMemWrData = '0;
        expNextPc = pc2;
        expHalt = 1'b0;
        if (mHalted) begin
                expNextPc = mPc;        // frozen so nothing happens
                return;
        end
        case (op)
                wiscPkg::HALT: begin
                        expHalt   = 1'b1;
                        expNextPc = mPc;
                end
                wiscPkg::ADDI:  setWb(ins[7:5], rs + i5s);
                wiscPkg::SUBI:  setWb(ins[7:5], i5s - rs);
                wiscPkg::XORI:  setWb(ins[7:5], rs ^ i5z);
                wiscPkg::ANDNI: setWb(ins[7:5], rs & ~i5z);
                wiscPkg::ROLI:  setWb(ins[7:5], rotLeft(rs, ins[3:0]));
                wiscPkg::SLLI:  setWb(ins[7:5], rs << ins[3:0]);
                wiscPkg::RORI:  setWb(ins[7:5], rotLeft(rs, (16 - ins[3:0]) % 16));
                wiscPkg::SRLI:  setWb(ins[7:5], rs >> ins[3:0]);
                wiscPkg::ST:    setStore(addr, rt);
                wiscPkg::LD:    setWb(ins[7:5], mMem[addr[8:1]]);
                wiscPkg::STU: begin
                        setStore(addr, rt);
                        setWb(ins[10:8], addr);     // updated base
                end
                wiscPkg::BTR: setWb(ins[4:2], rev);
                wiscPkg::SEQ: setWb(ins[4:2], {15'b0, rs == rt});
                wiscPkg::SLT: setWb(ins[4:2], {15'b0, $signed(rs) < $signed(rt)});
                wiscPkg::SLE: setWb(ins[4:2], {15'b0, $signed(rs) <= $signed(rt)});
                wiscPkg::SCO: setWb(ins[4:2], {15'b0, s[16]});
                wiscPkg::ADD_thru_ANDN: begin
                        case (ins[1:0])
                                2'b00:   setWb(ins[4:2], rs + rt);
                                2'b01:   setWb(ins[4:2], rt - rs);
                                2'b10:   setWb(ins[4:2], rs ^ rt);
                                default: setWb(ins[4:2], rs & ~rt);
                        endcase
                end
                wiscPkg::ROL_thru_SRL: begin
                        case (ins[1:0])
                                2'b00:   setWb(ins[4:2], rotLeft(rs, rt[3:0]));
                                2'b01:   setWb(ins[4:2], rs << rt[3:0]);
                                2'b10:   setWb(ins[4:2], rotLeft(rs, (16 - rt[3:0]) % 16));
                                default: setWb(ins[4:2], rs >> rt[3:0]);
                        endcase
                end
                wiscPkg::BEQZ, wiscPkg::BNEZ, wiscPkg::BLTZ, wiscPkg::BGEZ: begin
                        case (op[1:0])
                                2'b00:   cond = (rs == 16'd0);
                                2'b01:   cond = (rs != 16'd0);
                                2'b10:   cond = rs[15];
                                default: cond = !rs[15];
                        endcase
                        if (cond) expNextPc = (pc2 + i8s) & 16'hfffe;
                end
                wiscPkg::LBI:  setWb(ins[10:8], i8s);
                wiscPkg::SLBI: setWb(ins[10:8], {rs[7:0], ins[7:0]});
                wiscPkg::J:    expNextPc = (pc2 + i11) & 16'hfffe;
                wiscPkg::JR:   expNextPc = (rs + i8s) & 16'hfffe;
                wiscPkg::JAL: begin
                        expNextPc = (pc2 + i11) & 16'hfffe;
                        setWb(3'd7, pc2);
                end
                wiscPkg::JALR: begin
                        expNextPc = (rs + i8s) & 16'hfffe;  // rs read before link write
                        setWb(3'd7, pc2);
                end
                default: ;      // nop, siic, rti
        endcase
endtask

task automatic commitStep();
        if (expWbEn) mReg[expWbReg] = expWbData;
        if (expMemWrEn) mMem[expMemAddr[8:1]] = expMemWrData;
        if (expHalt) mHalted = 1'b1;
        else mPc = expNextPc;
endtask

`endif

// ==== testbench/tbWisc.sv ====
// testbench for the core with random programs, instruction memory,
// reference model compare and watchdog

module tbWisc;

        localparam int PROGS      = 8;
        localparam int PROG_WORDS = 256;
        localparam int STEP_LIMIT = PROG_WORDS * 4;     // random loops stop here
        localparam int PERIOD     = 20;
        localparam int MAX_CYCLES = PROGS * (STEP_LIMIT + 16);

        logic             clk;
        logic             rst;
        wiscPkg::word_t   instr;
        wiscPkg::word_t   instrAddr;
        logic             halted;
        logic             wbEn;
        logic             memWrEn;
        wiscPkg::regIdx_t wbReg;
        wiscPkg::word_t   wbData;
        wiscPkg::word_t   memAddr;
        wiscPkg::word_t   memWrData;
        wiscPkg::word_t   imem [PROG_WORDS];
        integer           seed;

        `include "wiscModel.svh"

        wiscCore dut (.clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
                .halted(halted), .wbEn(wbEn), .memWrEn(memWrEn), .wbReg(wbReg),
                .wbData(wbData), .memAddr(memAddr), .memWrData(memWrData));

        assign instr = imem[instrAddr[8:1]];    // combinational fetch that wraps at 512 bytes

        always #(PERIOD / 2) clk = ~clk;

        task automatic checkEq(input string name, input logic [15:0] got,
                        input logic [15:0] exp);
                if (got !== exp) begin
                        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
                        $display("Test FAILED");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        // compares one instruction in the low phase and advances the model
        task automatic compareCycle();
                @(negedge clk);
                predictStep(imem[mPc[8:1]]);
                checkEq("instrAddr", instrAddr, mPc);
                checkEq("halted", {15'b0, halted}, {15'b0, mHalted});
                checkEq("wbEn", {15'b0, wbEn}, {15'b0, expWbEn});
                checkEq("memWrEn", {15'b0, memWrEn}, {15'b0, expMemWrEn});
                if (expWbEn) begin
                        checkEq("wbReg", {13'b0, wbReg}, {13'b0, expWbReg});
                        checkEq("wbData", wbData, expWbData);
                end
                if (expMemWrEn) begin
                        checkEq("memAddr", memAddr, expMemAddr);
                        checkEq("memWrData", memWrData, expMemWrData);
                end
                commitStep();
        endtask

        task automatic loadProgram();
                wiscPkg::word_t w;
                for (int i = 0; i < PROG_WORDS - 1; i++) begin
                        w = $random(seed);
                        w[15:11] = 5'd1 + ($unsigned($random(seed)) % 31);  // any op but halt
                        if (w[15:13] == 3'b011) w[7] = 1'b0;    // forward branches
                        if (w[15:11] == wiscPkg::J || w[15:11] == wiscPkg::JAL)
                                w[10] = 1'b0;                   // forward jumps
                        imem[i] <= w;
                end
                imem[PROG_WORDS - 1] <= {wiscPkg::HALT, 11'b0};
        endtask

        task automatic runProgram();
                int steps;
                @(posedge clk);
                rst <= 1'b1;
                for (int i = 0; i < PROG_WORDS; i++) begin
                        imem[i] <= {wiscPkg::NOP, 3'b0, i[7:0]};   // indexed nop fill
                end
                repeat (7) @(posedge clk);
                @(negedge clk);
                checkEq("reset instrAddr", instrAddr, 16'd0);
                checkEq("reset halted", {15'b0, halted}, 16'd0);
                checkEq("reset wbEn", {15'b0, wbEn}, 16'd0);
                checkEq("reset memWrEn", {15'b0, memWrEn}, 16'd0);
                modelReset();
                @(posedge clk);
                rst <= 1'b0;
                loadProgram();          // new words appear as reset is released
                steps = 0;
                while (!mHalted && steps < STEP_LIMIT) begin
                        compareCycle();
                        steps++;
                end
                if (mHalted) begin
                        repeat (3) compareCycle();      // pc frozen and no strobes
                end
        endtask

        initial begin
                clk   = 1'b0;
                rst   = 1'b1;
                seed  = 86;
                for (int i = 0; i < PROG_WORDS; i++) imem[i] = {wiscPkg::NOP, 3'b0, i[7:0]};
                for (int p = 0; p < PROGS; p++) begin
                        runProgram();
                end
                $display("Test OK");
                $finish;
        end

        initial begin
                #(PERIOD * MAX_CYCLES);
                $display("run did not finish, core never halted in the cycle budget");
                $display("Test FAILED");
                $fatal(1, "watchdog expired");
        end

endmodule

// ==== rtl/wiscCore.sv ====
// core top level, blocks wired to plain ports
module wiscCore (
        input  logic             clk,
        input  logic             rst,
        input  wiscPkg::word_t   instr,
        output wiscPkg::word_t   instrAddr,
        output logic             halted,
        output logic             wbEn,
        output logic             memWrEn,
        output wiscPkg::regIdx_t wbReg,
        output wiscPkg::word_t   wbData,
        output wiscPkg::word_t   memAddr,
        output wiscPkg::word_t   memWrData
);

        ctrlIf ctl ();

        logic           running;
        logic           takeRedirect;
        wiscPkg::word_t redirectTarget;
        wiscPkg::word_t rdA;
        wiscPkg::word_t rdB;
        wiscPkg::word_t aluResult;
        wiscPkg::word_t storeData;
        wiscPkg::word_t linkAddr;

        assign wbEn  = ctl.regWrite & running;
        assign wbReg = (ctl.regDst == wiscPkg::dstR)  ? instr[4:2]  :
                       (ctl.regDst == wiscPkg::dstI2) ? instr[10:8] :
                       (ctl.regDst == wiscPkg::dstR7) ? wiscPkg::LINK_REG : instr[7:5];

        fetchUnit uFetch (.clk(clk), .rst(rst), .ctl(ctl.exe), .takeRedirect(takeRedirect),
                .redirectTarget(redirectTarget), .instrAddr(instrAddr), .running(running),
                .halted(halted));

        control uControl (.instr(instr), .ctl(ctl.dec));

        regFile uRegs (.clk(clk), .rst(rst), .rdIdxA(instr[10:8]), .rdIdxB(instr[7:5]),
                .wrIdx(wbReg), .wrEn(wbEn), .wrData(wbData), .rdA(rdA), .rdB(rdB));

        executeUnit uExec (.ctl(ctl.exe), .instr(instr), .pc(instrAddr), .rdA(rdA), .rdB(rdB),
                .aluResult(aluResult), .storeData(storeData), .linkAddr(linkAddr),
                .takeRedirect(takeRedirect), .redirectTarget(redirectTarget));

        memWriteback uMem (.clk(clk), .rst(rst), .running(running), .ctl(ctl.mem),
                .aluResult(aluResult), .storeData(storeData), .linkAddr(linkAddr),
                .wbData(wbData), .memAddr(memAddr), .memWrData(memWrData), .memWrEn(memWrEn));

endmodule

// ==== rtl/memWriteback.sv ====
// data memory and writeback data select
module memWriteback (
        input  logic           clk,
        input  logic           rst,
        input  logic           running,
        ctrlIf.mem             ctl,
        input  wiscPkg::word_t aluResult,
        input  wiscPkg::word_t storeData,
        input  wiscPkg::word_t linkAddr,
        output wiscPkg::word_t wbData,
        output wiscPkg::word_t memAddr,
        output wiscPkg::word_t memWrData,
        output logic           memWrEn
);

        wiscPkg::word_t dmem [wiscPkg::DMEM_DEPTH];
        logic [$clog2(wiscPkg::DMEM_DEPTH)-1:0] wordIdx;
        wiscPkg::word_t readData;

        assign memAddr   = aluResult;
        assign memWrData = storeData;
        assign memWrEn   = ctl.memWrite & running;  // no stores once halted
        assign wordIdx   = aluResult[8:1];          // byte address to word

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < wiscPkg::DMEM_DEPTH; i++) begin
                                dmem[i] <= '0;
                        end
                end else if (memWrEn) begin
                        dmem[wordIdx] <= storeData;
                end
        end

        assign readData = ctl.memRead ? dmem[wordIdx] : '0;     // async read

        always_comb begin
                if (ctl.memToReg) begin
                        wbData = readData;
                end else if (ctl.jump && ctl.regWrite) begin
                        wbData = linkAddr;      // jal, jalr
                end else begin
                        wbData = aluResult;
                end
        end

endmodule

// ==== rtl/executeUnit.sv ====
// immediate extension, alu, compares, bit reverse,
// branch condition and redirect target
module executeUnit (
        ctrlIf.exe             ctl,
        input  wiscPkg::word_t instr,
        input  wiscPkg::word_t pc,
        input  wiscPkg::word_t rdA,
        input  wiscPkg::word_t rdB,
        output wiscPkg::word_t aluResult,
        output wiscPkg::word_t storeData,
        output wiscPkg::word_t linkAddr,
        output logic           takeRedirect,
        output wiscPkg::word_t redirectTarget
);

        wiscPkg::word_t imm;
        wiscPkg::word_t opB;
        wiscPkg::word_t arithRes;
        wiscPkg::word_t shiftRes;
        wiscPkg::word_t revRes;
        wiscPkg::word_t pcInc;
        wiscPkg::word_t target;
        logic [16:0]    sum;        // carry kept for sco
        logic [31:0]    rotL;
        logic [31:0]    rotR;
        logic           branchCond;

        always_comb begin
                case (ctl.size)
                        wiscPkg::imm5: imm = ctl.zeroEx ? {11'b0, instr[4:0]}
                                : {{11{instr[4]}}, instr[4:0]};
                        wiscPkg::imm8: imm = ctl.zeroEx ? {8'b0, instr[7:0]}
                                : {{8{instr[7]}}, instr[7:0]};
                        default: imm = {{5{instr[10]}}, instr[10:0]};
                endcase
        end

        assign opB  = ctl.aluSrc ? imm : rdB;
        assign sum  = {1'b0, rdA} + {1'b0, opB};
        assign rotL = {rdA, rdA} << opB[3:0];   // rotate via doubled word
        assign rotR = {rdA, rdA} >> opB[3:0];

        always_comb begin
                case (ctl.aluF)
                        wiscPkg::fAddRol: arithRes = sum[15:0];
                        wiscPkg::fSubSll: arithRes = opB - rdA;     // second minus first
                        wiscPkg::fXorRor: arithRes = rdA ^ opB;
                        default:          arithRes = rdA & ~opB;
                endcase
                case (ctl.aluF)
                        wiscPkg::fAddRol: shiftRes = rotL[31:16];
                        wiscPkg::fSubSll: shiftRes = rdA << opB[3:0];
                        wiscPkg::fXorRor: shiftRes = rotR[15:0];
                        default:          shiftRes = rdA >> opB[3:0];
                endcase
                for (int i = 0; i < 16; i++) begin
                        revRes[i] = rdA[15 - i];
                end
        end

        always_comb begin
                case (ctl.opcode)
                        wiscPkg::ROLI, wiscPkg::SLLI, wiscPkg::RORI, wiscPkg::SRLI,
                        wiscPkg::ROL_thru_SRL: aluResult = shiftRes;
                        wiscPkg::BTR:  aluResult = revRes;
                        wiscPkg::SEQ:  aluResult = {15'b0, rdA == rdB};
                        wiscPkg::SLT:  aluResult = {15'b0, $signed(rdA) < $signed(rdB)};
                        wiscPkg::SLE:  aluResult = {15'b0, $signed(rdA) <= $signed(rdB)};
                        wiscPkg::SCO:  aluResult = {15'b0, sum[16]};
                        wiscPkg::LBI:  aluResult = imm;
                        wiscPkg::SLBI: aluResult = {rdA[7:0], imm[7:0]};
                        default:       aluResult = arithRes;    // also ld/st/stu address
                endcase
        end

        always_comb begin
                case (ctl.opcode[1:0])
                        2'b00:   branchCond = (rdA == '0);  // beqz
                        2'b01:   branchCond = (rdA != '0);  // bnez
                        2'b10:   branchCond = rdA[15];      // bltz
                        default: branchCond = ~rdA[15];     // bgez
                endcase
        end

        assign pcInc          = pc + 16'd2;
        assign linkAddr       = pcInc;
        assign storeData      = rdB;            // rd field of st/stu
        assign target         = (ctl.jump && ctl.aluSrc) ? sum[15:0] : pcInc + imm;  // jr/jalr
        assign redirectTarget = {target[15:1], 1'b0};       // fetch is halfword aligned
        assign takeRedirect   = ctl.jump | (ctl.branch & branchCond);

endmodule

// ==== rtl/regFile.sv ====
// eight 16-bit registers, two combinational reads and one write
module regFile (
        input  logic             clk,
        input  logic             rst,
        input  wiscPkg::regIdx_t rdIdxA,
        input  wiscPkg::regIdx_t rdIdxB,
        input  wiscPkg::regIdx_t wrIdx,
        input  logic             wrEn,
        input  wiscPkg::word_t   wrData,
        output wiscPkg::word_t   rdA,
        output wiscPkg::word_t   rdB
);

        wiscPkg::word_t regs [8];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < 8; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wrEn) begin
                        regs[wrIdx] <= wrData;      // commits at end of instruction
                end
        end

        assign rdA = regs[rdIdxA];  // no bypass, single cycle
        assign rdB = regs[rdIdxB];

        // writeback mux output must be settled by the edge
        wrKnown: assert property (@(posedge clk) disable iff (rst)
                wrEn |-> !$isunknown(wrData));

endmodule

// ==== rtl/control.sv ====
// opcode and function decoder, drives all control levels
// siic and rti fall through as nop
module control (
        input  wiscPkg::word_t instr,
        ctrlIf.dec             ctl
);

        always_comb begin
                ctl.opcode   = instr[15:11];    // passed on to execute
                ctl.size     = wiscPkg::imm5;
                ctl.zeroEx   = 1'b0;
                ctl.regDst   = wiscPkg::dstI1;
                ctl.aluSrc   = 1'b0;
                ctl.aluF     = wiscPkg::fAddRol;        // address add for ld/st
                ctl.branch   = 1'b0;
                ctl.jump     = 1'b0;
                ctl.memRead  = 1'b0;
                ctl.memWrite = 1'b0;
                ctl.memToReg = 1'b0;
                ctl.regWrite = 1'b0;
                ctl.halt     = 1'b0;
                case (instr[15:11])
                        wiscPkg::HALT: ctl.halt = 1'b1;         // freezes the pc
                        wiscPkg::ADDI, wiscPkg::SUBI, wiscPkg::ROLI, wiscPkg::SLLI,
                        wiscPkg::RORI, wiscPkg::SRLI: begin
                                ctl.aluSrc   = 1'b1;
                                ctl.regWrite = 1'b1;
                                ctl.aluF     = wiscPkg::aluFunc_e'(instr[12:11]);  // low opcode bits
                        end
                        wiscPkg::XORI, wiscPkg::ANDNI: begin
                                ctl.zeroEx   = 1'b1;            // logic ops zero extend
                                ctl.aluSrc   = 1'b1;
                                ctl.regWrite = 1'b1;
                                ctl.aluF     = wiscPkg::aluFunc_e'(instr[12:11]);
                        end
                        wiscPkg::ST: begin
                                ctl.aluSrc   = 1'b1;
                                ctl.memWrite = 1'b1;
                        end
                        wiscPkg::LD: begin
                                ctl.aluSrc   = 1'b1;
                                ctl.memRead  = 1'b1;
                                ctl.memToReg = 1'b1;
                                ctl.regWrite = 1'b1;
                        end
                        wiscPkg::STU: begin
                                ctl.regDst   = wiscPkg::dstI2;  // address back to rs
                                ctl.aluSrc   = 1'b1;
                                ctl.memWrite = 1'b1;
                                ctl.regWrite = 1'b1;
                        end
                        wiscPkg::BTR, wiscPkg::SEQ, wiscPkg::SLT, wiscPkg::SLE,
                        wiscPkg::SCO: begin
                                ctl.regDst   = wiscPkg::dstR;
                                ctl.regWrite = 1'b1;
                        end
                        wiscPkg::ADD_thru_ANDN, wiscPkg::ROL_thru_SRL: begin
                                ctl.regDst   = wiscPkg::dstR;
                                ctl.regWrite = 1'b1;
                                ctl.aluF     = wiscPkg::aluFunc_e'(instr[1:0]);    // r-format func
                        end
                        wiscPkg::BEQZ, wiscPkg::BNEZ, wiscPkg::BLTZ, wiscPkg::BGEZ: begin
                                ctl.size   = wiscPkg::imm8;
                                ctl.regDst = wiscPkg::dstI2;
                                ctl.branch = 1'b1;
                        end
                        wiscPkg::LBI, wiscPkg::SLBI: begin
                                ctl.size     = wiscPkg::imm8;
                                ctl.regDst   = wiscPkg::dstI2;
                                ctl.aluSrc   = 1'b1;
                                ctl.zeroEx   = instr[14] == 1'b0;   // slbi only
                                ctl.regWrite = 1'b1;
                        end
                        wiscPkg::J: begin
                                ctl.size = wiscPkg::imm11;
                                ctl.jump = 1'b1;
                        end
                        wiscPkg::JR: begin
                                ctl.size   = wiscPkg::imm8;
                                ctl.jump   = 1'b1;
                                ctl.aluSrc = 1'b1;                  // target from rs
                        end
                        wiscPkg::JAL: begin
                                ctl.size     = wiscPkg::imm11;
                                ctl.regDst   = wiscPkg::dstR7;
                                ctl.jump     = 1'b1;
                                ctl.regWrite = 1'b1;
                        end
                        wiscPkg::JALR: begin
                                ctl.size     = wiscPkg::imm8;
                                ctl.regDst   = wiscPkg::dstR7;
                                ctl.jump     = 1'b1;
                                ctl.aluSrc   = 1'b1;
                                ctl.regWrite = 1'b1;
                        end
                        default: begin
                                ctl.halt = 1'b0;    // nop, siic, rti
                        end
                endcase
        end

endmodule

// ==== rtl/fetchUnit.sv ====
// program counter, next-pc select and run/halted state machine
module fetchUnit (
        input  logic           clk,
        input  logic           rst,
        ctrlIf.exe             ctl,
        input  logic           takeRedirect,
        input  wiscPkg::word_t redirectTarget,
        output wiscPkg::word_t instrAddr,
        output logic           running,
        output logic           halted
);

        wiscPkg::word_t       pc;
        wiscPkg::word_t       nextPc;
        wiscPkg::fetchState_e state;

        assign nextPc = takeRedirect ? redirectTarget : pc + 16'd2;    // branch/jump or sequential

        always_ff @(posedge clk) begin
                if (rst) begin
                        pc    <= '0;
                        state <= wiscPkg::stRun;
                end else if (state == wiscPkg::stRun) begin
                        if (ctl.halt) begin
                                state <= wiscPkg::stHalted;     // pc held on the halt word
                        end else begin
                                pc <= nextPc;
                        end
                end
        end

        assign instrAddr = pc;
        assign running   = (state == wiscPkg::stRun);
        assign halted    = (state == wiscPkg::stHalted);

        // redirect targets come aligned from execute
        pcEven: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0);
        haltFrozen: assert property (@(posedge clk) disable iff (rst)
                halted |=> $stable(pc));

endmodule

// ==== rtl/ctrlIf.sv ====
// decoded control levels from the decoder to execute, fetch and memory
interface ctrlIf;

        wiscPkg::immSize_e size;        // immediate field width
        logic              zeroEx;      // zero extend instead of sign extend
        wiscPkg::regDst_e  regDst;      // write register select
        logic              aluSrc;      // immediate as second operand
        wiscPkg::aluFunc_e aluF;
        wiscPkg::opcode_t  opcode;
        logic              branch;
        logic              jump;
        logic              memRead;
        logic              memWrite;
        logic              memToReg;    // load data to register
        logic              regWrite;
        logic              halt;

        modport dec (output size, zeroEx, regDst, aluSrc, aluF, opcode, branch, jump,
                memRead, memWrite, memToReg, regWrite, halt);
        modport exe (input size, zeroEx, aluSrc, aluF, opcode, branch, jump, halt);
        modport mem (input memRead, memWrite, memToReg, regWrite, jump);

endinterface

// ==== rtl/wiscPkg.sv ====
// shared word types, opcode constants and control enums
// for the single-cycle 16-bit core
package wiscPkg;

        typedef logic [15:0] word_t;    // data, instruction or address
        typedef logic [2:0]  regIdx_t;  // register file index
        typedef logic [4:0]  opcode_t;  // instr[15:11]

        localparam opcode_t HALT          = 5'b00000;
        localparam opcode_t NOP           = 5'b00001;
        localparam opcode_t ADDI          = 5'b01000;
        localparam opcode_t SUBI          = 5'b01001;
        localparam opcode_t XORI          = 5'b01010;
        localparam opcode_t ANDNI         = 5'b01011;
        localparam opcode_t ROLI          = 5'b10100;
        localparam opcode_t SLLI          = 5'b10101;
        localparam opcode_t RORI          = 5'b10110;
        localparam opcode_t SRLI          = 5'b10111;
        localparam opcode_t ST            = 5'b10000;
        localparam opcode_t LD            = 5'b10001;
        localparam opcode_t STU           = 5'b10011;
        localparam opcode_t BTR           = 5'b11001;
        localparam opcode_t ADD_thru_ANDN = 5'b11011;
        localparam opcode_t ROL_thru_SRL  = 5'b11010;
        localparam opcode_t SEQ           = 5'b11100;
        localparam opcode_t SLT           = 5'b11101;
        localparam opcode_t SLE           = 5'b11110;
        localparam opcode_t SCO           = 5'b11111;
        localparam opcode_t BEQZ          = 5'b01100;
        localparam opcode_t BNEZ          = 5'b01101;
        localparam opcode_t BLTZ          = 5'b01110;
        localparam opcode_t BGEZ          = 5'b01111;
        localparam opcode_t LBI           = 5'b11000;
        localparam opcode_t SLBI          = 5'b10010;
        localparam opcode_t J             = 5'b00100;
        localparam opcode_t JR            = 5'b00101;
        localparam opcode_t JAL           = 5'b00110;
        localparam opcode_t JALR          = 5'b00111;
        localparam opcode_t SIIC          = 5'b00010;
        localparam opcode_t NOP_RTI       = 5'b00011;

        // function code, meaning depends on arith or shift opcode
        typedef enum logic [1:0] {fAddRol, fSubSll, fXorRor, fAndnSrl} aluFunc_e;
        typedef enum logic [1:0] {dstI1, dstR, dstI2, dstR7} regDst_e;
        typedef enum logic [1:0] {imm5, imm8, imm11} immSize_e;
        typedef enum logic {stRun, stHalted} fetchState_e;

        localparam int      DMEM_DEPTH = 256;   // data memory words
        localparam regIdx_t LINK_REG   = 3'd7;  // jal/jalr return register

endpackage
